//--- Makefile
# Verilator build and run of the cache subsystem testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -j 0 --top-module tb_cache_subsystem -f flist.f --Mdir obj_dir

run: compile
	./obj_dir/Vtb_cache_subsystem | tee run.log
	grep -q "TESTS PASSED" run.log

clean:
	rm -rf obj_dir run.log

//--- flist.f
rtl/cache_pkg.sv
rtl/cache_sram.sv
rtl/data_cache.sv
rtl/instr_cache.sv
rtl/mem_arbiter.sv
rtl/cache_subsystem.sv
verif/tb_clock_gen.sv
verif/tb_cache_subsystem.sv

//--- rtl/cache_pkg.sv
package cache_pkg;

    // Data path widths
    localparam int WORD_BITS = 32;
    localparam int MASK_BITS = 4;

    // Word addresses run from ADDR_HI down to bit 2
    localparam int ADDR_HI = 18;

    // Data cache controller
    typedef enum logic [2:0] {
        DC_IDLE,
        DC_CACHE_READ,
        DC_CACHE_WRITE,
        DC_MEM_READ,
        DC_MEM_WRITE,
        DC_DONE
    } dcache_state_e;

    // Instruction cache controller
    typedef enum logic [1:0] {
        IC_IDLE,
        IC_LOOKUP,
        IC_REFILL,
        IC_DONE
    } icache_state_e;

endpackage

//--- rtl/cache_sram.sv
module cache_sram #(
    parameter int INDEX_BITS = 9,
    parameter int TAG_BITS   = 8
) (
    input  logic                            clk_i,
    // Write port
    input  logic                            wr_en_i,
    input  logic [INDEX_BITS-1:0]           wr_index_i,
    input  logic [TAG_BITS-1:0]             wr_tag_i,
    input  logic [cache_pkg::WORD_BITS-1:0] wr_data_i,
    input  logic [cache_pkg::MASK_BITS-1:0] wr_mask_i,
    // Read port
    input  logic                            rd_en_i,
    input  logic [INDEX_BITS-1:0]           rd_index_i,
    output logic [TAG_BITS-1:0]             rd_tag_o,
    output logic [cache_pkg::WORD_BITS-1:0] rd_data_o
);

    localparam int LINES = 1 << INDEX_BITS;

    logic [TAG_BITS-1:0]             tag_mem  [LINES];
    logic [cache_pkg::WORD_BITS-1:0] data_mem [LINES];

    // Tag goes in on every write, data only where the mask is set
    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            tag_mem[wr_index_i] <= wr_tag_i;
            for (int b = 0; b < cache_pkg::MASK_BITS; b++) begin
                if (wr_mask_i[b]) begin
                    data_mem[wr_index_i][8*b +: 8] <= wr_data_i[8*b +: 8];
                end
            end
        end
        if (rd_en_i) begin
            rd_tag_o  <= tag_mem[rd_index_i];
            rd_data_o <= data_mem[rd_index_i];
        end
    end

endmodule

//--- rtl/cache_subsystem.sv
module cache_subsystem #(
    parameter int INDEX_BITS = 9,
    parameter int TAG_BITS   = 8
) (
    input  logic                            clk_i,
    input  logic                            rst_i,
    // Data core port
    input  logic                            dc_sel_i,
    input  logic [cache_pkg::ADDR_HI:2]     dc_addr_i,
    input  logic [cache_pkg::WORD_BITS-1:0] dc_wdata_i,
    input  logic [cache_pkg::MASK_BITS-1:0] dc_mask_i,
    output logic [cache_pkg::WORD_BITS-1:0] dc_rdata_o,
    output logic                            dc_stall_o,
    // Instruction core port
    input  logic                            ic_sel_i,
    input  logic [cache_pkg::ADDR_HI:2]     ic_addr_i,
    output logic [cache_pkg::WORD_BITS-1:0] ic_rdata_o,
    output logic                            ic_stall_o,
    // Main memory port
    output logic [cache_pkg::ADDR_HI:2]     mem_addr_o,
    output logic [cache_pkg::WORD_BITS-1:0] mem_wdata_o,
    output logic [cache_pkg::MASK_BITS-1:0] mem_wstrb_o,
    output logic                            mem_valid_o,
    input  logic [cache_pkg::WORD_BITS-1:0] mem_rdata_i,
    input  logic                            mem_ready_i
);

    // Miss ports between the caches and the arbiter
    logic [cache_pkg::ADDR_HI:2]     d_req_addr;
    logic [cache_pkg::WORD_BITS-1:0] d_req_wdata;
    logic [cache_pkg::MASK_BITS-1:0] d_req_wstrb;
    logic                            d_req_valid;
    logic [cache_pkg::WORD_BITS-1:0] d_rsp_rdata;
    logic                            d_rsp_ready;
    logic [cache_pkg::ADDR_HI:2]     i_req_addr;
    logic                            i_req_valid;
    logic [cache_pkg::WORD_BITS-1:0] i_rsp_rdata;
    logic                            i_rsp_ready;

    data_cache #(
        .INDEX_BITS (INDEX_BITS),
        .TAG_BITS   (TAG_BITS)
    ) u_data_cache (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .sel_i       (dc_sel_i),
        .addr_i      (dc_addr_i),
        .wdata_i     (dc_wdata_i),
        .mask_i      (dc_mask_i),
        .rdata_o     (dc_rdata_o),
        .stall_o     (dc_stall_o),
        .req_addr_o  (d_req_addr),
        .req_wdata_o (d_req_wdata),
        .req_wstrb_o (d_req_wstrb),
        .req_valid_o (d_req_valid),
        .rsp_rdata_i (d_rsp_rdata),
        .rsp_ready_i (d_rsp_ready)
    );

    instr_cache #(
        .INDEX_BITS (INDEX_BITS),
        .TAG_BITS   (TAG_BITS)
    ) u_instr_cache (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .sel_i       (ic_sel_i),
        .addr_i      (ic_addr_i),
        .rdata_o     (ic_rdata_o),
        .stall_o     (ic_stall_o),
        .req_addr_o  (i_req_addr),
        .req_valid_o (i_req_valid),
        .rsp_rdata_i (i_rsp_rdata),
        .rsp_ready_i (i_rsp_ready)
    );

    mem_arbiter u_mem_arbiter (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .d_addr_i    (d_req_addr),
        .d_wdata_i   (d_req_wdata),
        .d_wstrb_i   (d_req_wstrb),
        .d_valid_i   (d_req_valid),
        .d_rdata_o   (d_rsp_rdata),
        .d_ready_o   (d_rsp_ready),
        .i_addr_i    (i_req_addr),
        .i_valid_i   (i_req_valid),
        .i_rdata_o   (i_rsp_rdata),
        .i_ready_o   (i_rsp_ready),
        .mem_addr_o  (mem_addr_o),
        .mem_wdata_o (mem_wdata_o),
        .mem_wstrb_o (mem_wstrb_o),
        .mem_valid_o (mem_valid_o),
        .mem_rdata_i (mem_rdata_i),
        .mem_ready_i (mem_ready_i)
    );

endmodule

//--- rtl/data_cache.sv
module data_cache #(
    parameter int INDEX_BITS = 9,
    parameter int TAG_BITS   = 8
) (
    input  logic                            clk_i,
    input  logic                            rst_i,
    // Core side
    input  logic                            sel_i,
    input  logic [cache_pkg::ADDR_HI:2]     addr_i,
    input  logic [cache_pkg::WORD_BITS-1:0] wdata_i,
    input  logic [cache_pkg::MASK_BITS-1:0] mask_i,
    output logic [cache_pkg::WORD_BITS-1:0] rdata_o,
    output logic                            stall_o,
    // Miss port toward the arbiter
    output logic [cache_pkg::ADDR_HI:2]     req_addr_o,
    output logic [cache_pkg::WORD_BITS-1:0] req_wdata_o,
    output logic [cache_pkg::MASK_BITS-1:0] req_wstrb_o,
    output logic                            req_valid_o,
    input  logic [cache_pkg::WORD_BITS-1:0] rsp_rdata_i,
    input  logic                            rsp_ready_i
);

    localparam int LINES = 1 << INDEX_BITS;

    cache_pkg::dcache_state_e state_q, state_d;

    logic [LINES-1:0] valid_q;
    logic [LINES-1:0] dirty_q;

    // Word for the core, the victim on write-back, or the refill result
    logic [cache_pkg::WORD_BITS-1:0] line_q;
    logic [TAG_BITS-1:0]             victim_tag_q;
    // Set once a memory word has been fetched for this request
    logic                            refill_q;

    logic [INDEX_BITS-1:0]           index;
    logic [TAG_BITS-1:0]             tag;
    logic                            is_write;
    logic                            full_write;
    logic                            line_valid;
    logic                            line_dirty;
    logic                            tag_hit;
    logic [cache_pkg::WORD_BITS-1:0] merged;

    logic                            sram_wr_en;
    logic [cache_pkg::WORD_BITS-1:0] sram_wr_data;
    logic [cache_pkg::MASK_BITS-1:0] sram_wr_mask;
    logic                            sram_rd_en;
    logic [TAG_BITS-1:0]             sram_rd_tag;
    logic [cache_pkg::WORD_BITS-1:0] sram_rd_data;

    assign index      = addr_i[INDEX_BITS+1:2];
    assign tag        = addr_i[cache_pkg::ADDR_HI -: TAG_BITS];
    assign is_write   = |mask_i;
    assign full_write = &mask_i;
    assign line_valid = valid_q[index];
    assign line_dirty = dirty_q[index];
    assign tag_hit    = line_valid && (sram_rd_tag == tag);

    // Memory word with the core's masked bytes laid over it
    always_comb begin
        merged = rsp_rdata_i;
        for (int b = 0; b < cache_pkg::MASK_BITS; b++) begin
            if (mask_i[b]) begin
                merged[8*b +: 8] = wdata_i[8*b +: 8];
            end
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            cache_pkg::DC_IDLE: begin
                if (sel_i) begin
                    if (!is_write) begin
                        state_d = line_valid ? cache_pkg::DC_CACHE_READ
                                             : cache_pkg::DC_MEM_READ;
                    end else if (line_dirty) begin
                        // Dirty line needs a tag check before it is touched
                        state_d = cache_pkg::DC_CACHE_READ;
                    end else if (full_write) begin
                        state_d = cache_pkg::DC_CACHE_WRITE;
                    end else begin
                        state_d = cache_pkg::DC_MEM_READ;
                    end
                end
            end
            cache_pkg::DC_CACHE_READ: begin
                if (tag_hit) begin
                    state_d = is_write ? cache_pkg::DC_CACHE_WRITE : cache_pkg::DC_DONE;
                end else if (line_dirty) begin
                    state_d = cache_pkg::DC_MEM_WRITE;
                end else begin
                    state_d = cache_pkg::DC_MEM_READ;
                end
            end
            cache_pkg::DC_MEM_WRITE: begin
                // Victim is out, a whole-word write needs no fetch
                if (rsp_ready_i) begin
                    state_d = full_write ? cache_pkg::DC_CACHE_WRITE
                                         : cache_pkg::DC_MEM_READ;
                end
            end
            cache_pkg::DC_MEM_READ: begin
                if (rsp_ready_i) begin
                    state_d = cache_pkg::DC_CACHE_WRITE;
                end
            end
            cache_pkg::DC_CACHE_WRITE: begin
                state_d = cache_pkg::DC_DONE;
            end
            cache_pkg::DC_DONE: begin
                state_d = cache_pkg::DC_IDLE;
            end
            default: begin
                state_d = cache_pkg::DC_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q  <= cache_pkg::DC_IDLE;
            valid_q  <= '0;
            dirty_q  <= '0;
            refill_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == cache_pkg::DC_MEM_READ && rsp_ready_i) begin
                refill_q <= 1'b1;
            end else if (state_q == cache_pkg::DC_DONE) begin
                refill_q <= 1'b0;
            end
            if (state_q == cache_pkg::DC_CACHE_WRITE) begin
                valid_q[index] <= 1'b1;
                // A plain read refill leaves the line clean
                dirty_q[index] <= refill_q ? is_write : 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == cache_pkg::DC_CACHE_READ) begin
            line_q       <= sram_rd_data;
            victim_tag_q <= sram_rd_tag;
        end else if (state_q == cache_pkg::DC_MEM_READ && rsp_ready_i) begin
            line_q <= merged;
        end
    end

    // SRAM write either stores a fetched word whole or the core bytes
    assign sram_rd_en   = (state_q == cache_pkg::DC_IDLE) && sel_i;
    assign sram_wr_en   = (state_q == cache_pkg::DC_CACHE_WRITE);
    assign sram_wr_data = refill_q ? line_q : wdata_i;
    assign sram_wr_mask = refill_q ? {cache_pkg::MASK_BITS{1'b1}} : mask_i;

    cache_sram #(
        .INDEX_BITS (INDEX_BITS),
        .TAG_BITS   (TAG_BITS)
    ) u_sram (
        .clk_i      (clk_i),
        .wr_en_i    (sram_wr_en),
        .wr_index_i (index),
        .wr_tag_i   (tag),
        .wr_data_i  (sram_wr_data),
        .wr_mask_i  (sram_wr_mask),
        .rd_en_i    (sram_rd_en),
        .rd_index_i (index),
        .rd_tag_o   (sram_rd_tag),
        .rd_data_o  (sram_rd_data)
    );

    // Write-back goes to the victim's own address
    assign req_valid_o = (state_q == cache_pkg::DC_MEM_READ) ||
                         (state_q == cache_pkg::DC_MEM_WRITE);
    assign req_addr_o  = (state_q == cache_pkg::DC_MEM_WRITE) ? {victim_tag_q, index} : addr_i;
    assign req_wdata_o = (state_q == cache_pkg::DC_MEM_WRITE) ? line_q : '0;
    assign req_wstrb_o = (state_q == cache_pkg::DC_MEM_WRITE) ? {cache_pkg::MASK_BITS{1'b1}}
                                                              : '0;

    assign rdata_o = line_q;
    assign stall_o = sel_i && (state_q != cache_pkg::DC_DONE);

endmodule

//--- rtl/instr_cache.sv
module instr_cache #(
    parameter int INDEX_BITS = 9,
    parameter int TAG_BITS   = 8
) (
    input  logic                            clk_i,
    input  logic                            rst_i,
    // Fetch side
    input  logic                            sel_i,
    input  logic [cache_pkg::ADDR_HI:2]     addr_i,
    output logic [cache_pkg::WORD_BITS-1:0] rdata_o,
    output logic                            stall_o,
    // Miss port, reads only
    output logic [cache_pkg::ADDR_HI:2]     req_addr_o,
    output logic                            req_valid_o,
    input  logic [cache_pkg::WORD_BITS-1:0] rsp_rdata_i,
    input  logic                            rsp_ready_i
);

    localparam int LINES = 1 << INDEX_BITS;

    cache_pkg::icache_state_e state_q, state_d;

    logic [LINES-1:0]                valid_q;
    logic [cache_pkg::WORD_BITS-1:0] rdata_q;

    logic [INDEX_BITS-1:0]           index;
    logic [TAG_BITS-1:0]             tag;
    logic                            fill_done;
    logic [TAG_BITS-1:0]             sram_rd_tag;
    logic [cache_pkg::WORD_BITS-1:0] sram_rd_data;

    assign index     = addr_i[INDEX_BITS+1:2];
    assign tag       = addr_i[cache_pkg::ADDR_HI -: TAG_BITS];
    assign fill_done = (state_q == cache_pkg::IC_REFILL) && rsp_ready_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            cache_pkg::IC_IDLE:   if (sel_i) state_d = cache_pkg::IC_LOOKUP;
            cache_pkg::IC_LOOKUP: begin
                if (valid_q[index] && sram_rd_tag == tag) begin
                    state_d = cache_pkg::IC_DONE;
                end else begin
                    state_d = cache_pkg::IC_REFILL;
                end
            end
            cache_pkg::IC_REFILL: if (rsp_ready_i) state_d = cache_pkg::IC_DONE;
            default:              state_d = cache_pkg::IC_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= cache_pkg::IC_IDLE;
            valid_q <= '0;
        end else begin
            state_q <= state_d;
            if (fill_done) valid_q[index] <= 1'b1;
        end
    end

    // Hit word from the SRAM, or the fetched word on a refill
    always_ff @(posedge clk_i) begin
        if (state_q == cache_pkg::IC_LOOKUP) begin
            rdata_q <= sram_rd_data;
        end else if (fill_done) begin
            rdata_q <= rsp_rdata_i;
        end
    end

    cache_sram #(
        .INDEX_BITS (INDEX_BITS),
        .TAG_BITS   (TAG_BITS)
    ) u_sram (
        .clk_i      (clk_i),
        .wr_en_i    (fill_done),
        .wr_index_i (index),
        .wr_tag_i   (tag),
        .wr_data_i  (rsp_rdata_i),
        .wr_mask_i  ({cache_pkg::MASK_BITS{1'b1}}),
        .rd_en_i    ((state_q == cache_pkg::IC_IDLE) && sel_i),
        .rd_index_i (index),
        .rd_tag_o   (sram_rd_tag),
        .rd_data_o  (sram_rd_data)
    );

    assign req_addr_o  = addr_i;
    assign req_valid_o = (state_q == cache_pkg::IC_REFILL);
    assign rdata_o     = rdata_q;
    assign stall_o     = sel_i && (state_q != cache_pkg::IC_DONE);

endmodule

//--- rtl/mem_arbiter.sv
module mem_arbiter (
    input  logic                            clk_i,
    input  logic                            rst_i,
    // Data cache miss port
    input  logic [cache_pkg::ADDR_HI:2]     d_addr_i,
    input  logic [cache_pkg::WORD_BITS-1:0] d_wdata_i,
    input  logic [cache_pkg::MASK_BITS-1:0] d_wstrb_i,
    input  logic                            d_valid_i,
    output logic [cache_pkg::WORD_BITS-1:0] d_rdata_o,
    output logic                            d_ready_o,
    // Instruction cache miss port
    input  logic [cache_pkg::ADDR_HI:2]     i_addr_i,
    input  logic                            i_valid_i,
    output logic [cache_pkg::WORD_BITS-1:0] i_rdata_o,
    output logic                            i_ready_o,
    // Main memory
    output logic [cache_pkg::ADDR_HI:2]     mem_addr_o,
    output logic [cache_pkg::WORD_BITS-1:0] mem_wdata_o,
    output logic [cache_pkg::MASK_BITS-1:0] mem_wstrb_o,
    output logic                            mem_valid_o,
    input  logic [cache_pkg::WORD_BITS-1:0] mem_rdata_i,
    input  logic                            mem_ready_i
);

    // Owner is held while a transfer waits on ready
    logic busy_q;
    logic owner_instr_q;
    logic owner_instr;

    // When free, data side wins
    assign owner_instr = busy_q ? owner_instr_q : !d_valid_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            busy_q        <= 1'b0;
            owner_instr_q <= 1'b0;
        end else if (mem_valid_o && mem_ready_i) begin
            busy_q <= 1'b0;
        end else if (!busy_q && mem_valid_o) begin
            busy_q        <= 1'b1;
            owner_instr_q <= owner_instr;
        end
    end

    // Granted request passes straight through
    assign mem_valid_o = owner_instr ? i_valid_i : d_valid_i;
    assign mem_addr_o  = owner_instr ? i_addr_i : d_addr_i;
    assign mem_wdata_o = owner_instr ? '0 : d_wdata_i;
    assign mem_wstrb_o = owner_instr ? '0 : d_wstrb_i;

    assign d_rdata_o = mem_rdata_i;
    assign i_rdata_o = mem_rdata_i;
    assign d_ready_o = mem_ready_i && mem_valid_o && !owner_instr;
    assign i_ready_o = mem_ready_i && mem_valid_o && owner_instr;

endmodule

//--- verif/tb_cache_subsystem.sv
module tb_cache_subsystem;

    localparam int ADDR_W          = cache_pkg::ADDR_HI - 1;
    localparam int WORDS           = 1 << ADDR_W;
    localparam int CYCLES_PER_TEST = 40;

    typedef logic [cache_pkg::ADDR_HI:2]     waddr_t;
    typedef logic [cache_pkg::WORD_BITS-1:0] word_t;
    typedef logic [cache_pkg::MASK_BITS-1:0] mask_t;

    // Port an entry drives, or OP_MEM to compare main memory with the shadow
    typedef enum int {
        OP_DATA,
        OP_FETCH,
        OP_BOTH,
        OP_MEM
    } op_e;

    logic   clk;
    logic   rst;
    logic   dc_sel;
    waddr_t dc_addr;
    word_t  dc_wdata;
    mask_t  dc_mask;
    word_t  dc_rdata;
    logic   dc_stall;
    logic   ic_sel;
    waddr_t ic_addr;
    word_t  ic_rdata;
    logic   ic_stall;
    waddr_t mem_addr;
    word_t  mem_wdata;
    mask_t  mem_wstrb;
    logic   mem_valid;
    word_t  mem_rdata;
    logic   mem_ready;

    // Main memory and the value the data side should see at each address
    word_t mem    [WORDS];
    word_t shadow [WORDS];
    int    write_count;

    // Table columns are name, op, data address, fetch address, data, mask,
    // no write-back allowed, expected data word and expected fetch word
    string  t_name[$];
    op_e    t_op[$];
    waddr_t t_addr[$];
    waddr_t t_iaddr[$];
    word_t  t_data[$];
    mask_t  t_mask[$];
    bit     t_no_wb[$];
    word_t  t_exp[$];
    word_t  t_iexp[$];

    tb_clock_gen u_clock_gen (
        .clk_o (clk),
        .rst_o (rst)
    );

    cache_subsystem #(
        .INDEX_BITS (9),
        .TAG_BITS   (8)
    ) DUT (
        .clk_i       (clk),
        .rst_i       (rst),
        .dc_sel_i    (dc_sel),
        .dc_addr_i   (dc_addr),
        .dc_wdata_i  (dc_wdata),
        .dc_mask_i   (dc_mask),
        .dc_rdata_o  (dc_rdata),
        .dc_stall_o  (dc_stall),
        .ic_sel_i    (ic_sel),
        .ic_addr_i   (ic_addr),
        .ic_rdata_o  (ic_rdata),
        .ic_stall_o  (ic_stall),
        .mem_addr_o  (mem_addr),
        .mem_wdata_o (mem_wdata),
        .mem_wstrb_o (mem_wstrb),
        .mem_valid_o (mem_valid),
        .mem_rdata_i (mem_rdata),
        .mem_ready_i (mem_ready)
    );

    function automatic word_t lcg_step(input word_t state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // Byte lanes with a mask bit set come from the new word
    function automatic word_t merge_bytes(input word_t old_word, input word_t new_word,
                                          input mask_t mask);
        word_t result;
        result = old_word;
        for (int b = 0; b < cache_pkg::MASK_BITS; b++) begin
            if (mask[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("Fail %s: expected %08h, actual %08h", name, expected, actual);
            $display("TESTS FAILED");
            $fatal(1, "run stopped at the first mismatch");
        end
    endtask

    task automatic add_entry(input string name, input op_e op, input waddr_t addr,
                             input waddr_t iaddr, input word_t data, input mask_t mask,
                             input bit no_wb);
        t_name.push_back(name);
        t_op.push_back(op);
        t_addr.push_back(addr);
        t_iaddr.push_back(iaddr);
        t_data.push_back(data);
        t_mask.push_back(mask);
        t_no_wb.push_back(no_wb);
        t_exp.push_back('0);
        t_iexp.push_back('0);
    endtask

    // Code region sits at 17'h1E000 and up with the data side below it
    task automatic build_table();
        add_entry("rd_miss", OP_DATA, 17'h00100, '0, '0, 4'h0, 1'b0);
        add_entry("rd_hit", OP_DATA, 17'h00100, '0, '0, 4'h0, 1'b0);
        add_entry("wr_full_clean", OP_DATA, 17'h00204, '0, 32'hcafe_f00d, 4'hf, 1'b1);
        add_entry("rd_after_wr", OP_DATA, 17'h00204, '0, '0, 4'h0, 1'b1);
        add_entry("wr_byte_miss", OP_DATA, 17'h00308, '0, 32'h1122_3344, 4'h5, 1'b0);
        add_entry("rd_merged", OP_DATA, 17'h00308, '0, '0, 4'h0, 1'b0);
        add_entry("wr_dirty_a", OP_DATA, 17'h02020, '0, 32'ha5a5_5a5a, 4'hf, 1'b0);
        add_entry("rd_conflict_b", OP_DATA, 17'h02220, '0, '0, 4'h0, 1'b0);
        add_entry("mem_holds_a", OP_MEM, 17'h02020, '0, '0, 4'h0, 1'b0);
        add_entry("rd_back_a", OP_DATA, 17'h02020, '0, '0, 4'h0, 1'b0);
        add_entry("fetch_0", OP_FETCH, '0, 17'h1e000, '0, 4'h0, 1'b0);
        add_entry("fetch_1", OP_FETCH, '0, 17'h1e001, '0, 4'h0, 1'b0);
        add_entry("fetch_0_hit", OP_FETCH, '0, 17'h1e000, '0, 4'h0, 1'b0);
        add_entry("both_rd_miss", OP_BOTH, 17'h00410, 17'h1e002, '0, 4'h0, 1'b0);
        // Partial write over the dirty line at 17'h00308
        add_entry("both_wb_merge", OP_BOTH, 17'h04508, 17'h1e003, 32'h7788_99aa, 4'h3, 1'b0);
        add_entry("mem_holds_308", OP_MEM, 17'h00308, '0, '0, 4'h0, 1'b0);
        add_entry("rd_4508_hit", OP_DATA, 17'h04508, '0, '0, 4'h0, 1'b0);
        add_entry("both_hit", OP_BOTH, 17'h00100, 17'h1e001, '0, 4'h0, 1'b0);
    endtask

    task automatic run_access(input int i);
        int wb_before;
        wb_before = write_count;
        dc_sel    = 1'b1;
        dc_addr   = t_addr[i];
        dc_wdata  = t_data[i];
        dc_mask   = t_mask[i];
        do begin
            @(negedge clk);
        end while (dc_stall);
        if (t_mask[i] == '0) begin
            check_value(t_name[i], t_exp[i], dc_rdata);
        end else begin
            shadow[t_addr[i]] = merge_bytes(t_exp[i], t_data[i], t_mask[i]);
        end
        // Held through the completing edge and released after it
        @(negedge clk);
        dc_sel  = 1'b0;
        dc_mask = '0;
        if (t_no_wb[i]) begin
            check_value({t_name[i], " write-backs"}, 32'(wb_before), 32'(write_count));
        end
    endtask

    task automatic run_fetch(input int i);
        ic_sel  = 1'b1;
        ic_addr = t_iaddr[i];
        do begin
            @(negedge clk);
        end while (ic_stall);
        check_value({t_name[i], " fetch"}, t_iexp[i], ic_rdata);
        @(negedge clk);
        ic_sel = 1'b0;
    endtask

    // Memory model answers after 0 to 3 cycles and applies writes at ready
    initial begin : memory_model
        word_t seed;
        int    delay;
        seed = 32'd55;
        for (int a = 0; a < WORDS; a++) begin
            seed                = lcg_step(seed);
            mem[ADDR_W'(a)] = seed;
        end
        write_count = 0;
        mem_ready   = 1'b0;
        mem_rdata   = '0;
        delay       = 0;
        forever begin
            @(negedge clk);
            if (mem_ready) begin
                // Transfer ended on the last rising edge
                mem_ready = 1'b0;
                seed      = lcg_step(seed);
                delay     = int'(seed[17:16]);
            end else if (mem_valid) begin
                if (delay == 0) begin
                    mem_ready = 1'b1;
                    mem_rdata = mem[mem_addr];
                    if (mem_wstrb != '0) begin
                        mem[mem_addr] = merge_bytes(mem[mem_addr], mem_wdata, mem_wstrb);
                        write_count++;
                    end
                end else begin
                    delay--;
                end
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles >= t_name.size() * CYCLES_PER_TEST) begin
                $display("Timeout: the tests did not finish within %0d cycles", cycles);
                $display("TESTS FAILED");
                $fatal(1, "simulation ran too long");
            end
        end
    end

    initial begin : stimulus
        word_t seed;
        dc_sel   = 1'b0;
        dc_addr  = '0;
        dc_wdata = '0;
        dc_mask  = '0;
        ic_sel   = 1'b0;
        ic_addr  = '0;
        // Same sequence as the memory preload
        seed = 32'd55;
        for (int a = 0; a < WORDS; a++) begin
            seed                   = lcg_step(seed);
            shadow[ADDR_W'(a)] = seed;
        end
        build_table();
        // Reset must be seen high before its release counts
        wait (rst);
        wait (!rst);
        @(negedge clk);
        check_value("reset_idle", 32'd0, 32'({dc_stall, ic_stall, mem_valid}));
        for (int i = 0; i < t_name.size(); i++) begin
            t_exp[i]  = shadow[t_addr[i]];
            t_iexp[i] = shadow[t_iaddr[i]];
            case (t_op[i])
                OP_DATA: run_access(i);
                OP_FETCH: run_fetch(i);
                OP_BOTH: begin
                    fork
                        run_access(i);
                        run_fetch(i);
                    join
                end
                default: check_value(t_name[i], t_exp[i], mem[t_addr[i]]);
            endcase
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule

//--- verif/tb_clock_gen.sv
module tb_clock_gen (
    output logic clk_o,
    output logic rst_o
);

    // Period of 10
    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    // Reset over three rising edges, released on a falling edge
    initial begin
        rst_o = 1'b1;
        repeat (3) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b0;
    end

endmodule
